// File: bench/rtab_clkgen.sv
// Testbench clock and power-on reset source, instantiated once by the replay table testbench
`timescale 1ns/1ns
`default_nettype none

module rtab_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released just after a rising edge, clear of the DUT flops
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/rtab_props.sv
// Protocol properties of the replay table ports, bound to rtab_top by the testbench
`timescale 1ns/1ns
`default_nettype none

module rtab_props (
    input logic                clk_i,
    input logic                rst_ni,
    input logic                alloc_i,
    input logic                alloc_link_i,
    input logic                full_i,
    input logic                pop_try_i,
    input rtab_pkg::rtab_ptr_t pop_try_ptr_i,
    input logic                pop_commit_i,
    input rtab_pkg::rtab_ptr_t pop_commit_ptr_i,
    input logic                pop_rback_i,
    input rtab_pkg::rtab_ptr_t pop_rback_ptr_i
);
    int unsigned fails = 0;

    // Every accepted pop is answered by exactly one of commit or rollback
    a_pop_answered: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_try_i |=> (pop_commit_i != pop_rback_i))
        else begin
            $error("pop try not followed by exactly one commit or rollback");
            fails++;
        end

    // The answer carries the pointer that was offered
    a_pop_ptr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_try_i |=> ((pop_commit_i ? pop_commit_ptr_i : pop_rback_ptr_i)
                       == $past(pop_try_ptr_i)))
        else begin
            $error("commit or rollback pointer differs from the popped pointer");
            fails++;
        end

    a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alloc_i || alloc_link_i) |-> !full_i)
        else begin
            $error("allocation while the table is full");
            fails++;
        end

    a_alloc_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(alloc_i && alloc_link_i))
        else begin
            $error("plain and linked allocation in the same cycle");
            fails++;
        end

    a_no_pop_in_rback: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> !pop_try_i)
        else begin
            $error("pop try during a rollback");
            fails++;
        end

endmodule

`default_nettype wire

// File: bench/rtab_tb.sv
// Directed testbench for the replay table that drives rtab_top as the DUT and is the simulation top
`timescale 1ns/1ns
`default_nettype none

module rtab_tb;
    import rtab_pkg::*;

    localparam int unsigned SEED         = 32'hc07476f2;
    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 8;
    // All tests together take about 70 cycles
    localparam int          MAX_CYCLES   = 2000;
    localparam int          WAIT_LIMIT   = 16;

    localparam rtab_deps_t DEPS_NONE  = '{mshr_hit: 1'b0, mshr_ready: 1'b0};
    localparam rtab_deps_t WAIT_MISS  = '{mshr_hit: 1'b1, mshr_ready: 1'b0};
    localparam rtab_deps_t WAIT_READY = '{mshr_hit: 1'b0, mshr_ready: 1'b1};

    logic               clk;
    logic               rst_n;
    logic [NLINE_W-1:0] check_nline;
    logic               check_hit;
    logic               alloc;
    logic               alloc_link;
    rtab_req_t          alloc_req;
    rtab_deps_t         alloc_deps;
    logic               pop_try_valid;
    logic               pop_try;
    rtab_req_t          pop_try_req;
    rtab_ptr_t          pop_try_ptr;
    logic               pop_commit;
    rtab_ptr_t          pop_commit_ptr;
    logic               pop_rback;
    rtab_ptr_t          pop_rback_ptr;
    rtab_deps_t         pop_rback_deps;
    logic               refill;
    logic [NLINE_W-1:0] refill_nline;
    logic               miss_ready;
    logic               empty;
    logic               full;

    // Reference copy of what the table should hold
    rtab_req_t          model_req [RTAB_ENTRIES];
    rtab_vec_t          model_valid;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;

    rtab_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    rtab_top UUT (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .check_nline_i    (check_nline),
        .check_hit_o      (check_hit),
        .alloc_i          (alloc),
        .alloc_link_i     (alloc_link),
        .alloc_req_i      (alloc_req),
        .alloc_deps_i     (alloc_deps),
        .pop_try_valid_o  (pop_try_valid),
        .pop_try_i        (pop_try),
        .pop_try_req_o    (pop_try_req),
        .pop_try_ptr_o    (pop_try_ptr),
        .pop_commit_i     (pop_commit),
        .pop_commit_ptr_i (pop_commit_ptr),
        .pop_rback_i      (pop_rback),
        .pop_rback_ptr_i  (pop_rback_ptr),
        .pop_rback_deps_i (pop_rback_deps),
        .refill_i         (refill),
        .refill_nline_i   (refill_nline),
        .miss_ready_i     (miss_ready),
        .empty_o          (empty),
        .full_o           (full)
    );

    bind rtab_top rtab_props u_props (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .alloc_i          (alloc_i),
        .alloc_link_i     (alloc_link_i),
        .full_i           (full_o),
        .pop_try_i        (pop_try_i),
        .pop_try_ptr_i    (pop_try_ptr_o),
        .pop_commit_i     (pop_commit_i),
        .pop_commit_ptr_i (pop_commit_ptr_i),
        .pop_rback_i      (pop_rback_i),
        .pop_rback_ptr_i  (pop_rback_ptr_i)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped at %0t ns, tests did not finish in %0d cycles", $time, cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic rtab_req_t make_req(input logic [NLINE_W-1:0] nline, input rtab_op_e op);
        rtab_req_t req;
        req.nline  = nline;
        req.offset = OFFSET_W'($urandom);
        req.op     = op;
        req.id     = ID_W'($urandom);
        return req;
    endfunction

    function automatic rtab_ptr_t lowest_free();
        rtab_ptr_t slot;
        slot = '0;
        for (int i = RTAB_ENTRIES - 1; i >= 0; i--) begin
            if (!model_valid[i]) begin
                slot = rtab_ptr_t'(i);
            end
        end
        return slot;
    endfunction

    task automatic allocate(input rtab_req_t req, input rtab_deps_t deps, input logic link,
                            output rtab_ptr_t slot);
        slot       = lowest_free();
        alloc      = !link;
        alloc_link = link;
        alloc_req  = req;
        alloc_deps = deps;
        if (link) begin
            check_nline = req.nline;
            #1;
            check_value("check_hit_o", check_hit, 1);
        end
        model_valid[slot] = 1'b1;
        model_req[slot]   = req;
        step();
        alloc      = 1'b0;
        alloc_link = 1'b0;
        alloc_deps = DEPS_NONE;
    endtask

    task automatic expect_offer(input rtab_ptr_t ptr);
        check_value("pop_try_valid_o", pop_try_valid, 1);
        check_value("pop_try_ptr_o", pop_try_ptr, ptr);
        check_value("pop_try_req_o", pop_try_req, model_req[ptr]);
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            check_value("pop_try_valid_o", pop_try_valid, 0);
            step();
        end
    endtask

    task automatic wait_offer(output logic ok);
        int n;
        n = 0;
        while (!pop_try_valid && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        ok = pop_try_valid;
        assert (ok) else begin
            $display("No entry was offered within %0d cycles, at %0t ns", WAIT_LIMIT, $time);
            errors++;
        end
    endtask

    task automatic accept_pop(output rtab_ptr_t ptr);
        ptr     = pop_try_ptr;
        pop_try = 1'b1;
        step();
        pop_try = 1'b0;
    endtask

    task automatic commit_entry(input rtab_ptr_t ptr);
        pop_commit     = 1'b1;
        pop_commit_ptr = ptr;
        step();
        pop_commit       = 1'b0;
        model_valid[ptr] = 1'b0;
    endtask

    task automatic pulse_refill(input logic [NLINE_W-1:0] nline);
        refill       = 1'b1;
        refill_nline = nline;
        step();
        refill = 1'b0;
    endtask

    // Pops and commits every live entry in whatever order the table offers them
    task automatic drain_all();
        logic      ok;
        rtab_ptr_t p;
        ok = 1'b1;
        while (ok && model_valid != '0) begin
            wait_offer(ok);
            if (ok) begin
                p = pop_try_ptr;
                check_value("live entry at pop_try_ptr_o", model_valid[p], 1);
                check_value("pop_try_req_o", pop_try_req, model_req[p]);
                accept_pop(p);
                commit_entry(p);
            end
        end
        check_value("empty_o", empty, 1);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors > start_errors) begin
            tests_failed++;
            $display("%-20s FAIL, %0d errors", name, errors - start_errors);
        end else begin
            $display("%-20s ok", name);
        end
    endtask

    task automatic reset_and_fill();
        int        start;
        rtab_ptr_t s;
        start = errors;
        check_value("empty_o", empty, 1);
        check_value("full_o", full, 0);
        check_value("pop_try_valid_o", pop_try_valid, 0);
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            check_value("full_o", full, 0);
            allocate(make_req(NLINE_W'(16 * (i + 1)), OP_LOAD), WAIT_READY, 1'b0, s);
        end
        check_value("full_o", full, 1);
        check_value("empty_o", empty, 0);
        check_value("pop_try_valid_o", pop_try_valid, 0);
        check_nline = 8'h30;
        step();
        check_value("check_hit_o", check_hit, 1);
        check_nline = 8'h55;
        step();
        check_value("check_hit_o", check_hit, 0);
        miss_ready = 1'b1;
        step();
        miss_ready = 1'b0;
        drain_all();
        finish_test("reset_and_fill", start);
    endtask

    task automatic replay_with_commit();
        int        start;
        rtab_ptr_t s;
        rtab_ptr_t p;
        start = errors;
        allocate(make_req(8'hA5, OP_STORE), DEPS_NONE, 1'b0, s);
        expect_offer(s);
        accept_pop(p);
        commit_entry(p);
        check_value("empty_o", empty, 1);
        check_value("pop_try_valid_o", pop_try_valid, 0);
        finish_test("replay_with_commit", start);
    endtask

    task automatic list_order();
        int        start;
        rtab_ptr_t s [3];
        start = errors;
        allocate(make_req(8'h77, OP_LOAD), DEPS_NONE, 1'b0, s[0]);
        allocate(make_req(8'h77, OP_STORE), DEPS_NONE, 1'b1, s[1]);
        allocate(make_req(8'h77, OP_LOAD), DEPS_NONE, 1'b1, s[2]);
        // Each pop overlaps the commit of the one before
        for (int i = 0; i < 3; i++) begin
            expect_offer(s[i]);
            pop_try = 1'b1;
            if (i > 0) begin
                pop_commit     = 1'b1;
                pop_commit_ptr = s[i-1];
            end
            step();
            pop_try    = 1'b0;
            pop_commit = 1'b0;
            if (i > 0) begin
                model_valid[s[i-1]] = 1'b0;
            end
        end
        commit_entry(s[2]);
        check_value("empty_o", empty, 1);
        finish_test("list_order", start);
    endtask

    task automatic dependency_wait();
        int        start;
        rtab_ptr_t a;
        rtab_ptr_t b;
        rtab_ptr_t p;
        start = errors;
        allocate(make_req(8'h5A, OP_LOAD), WAIT_MISS, 1'b0, a);
        allocate(make_req(8'h6B, OP_PREFETCH), WAIT_READY, 1'b0, b);
        expect_quiet(2);
        pulse_refill(8'h99);
        expect_quiet(3);
        pulse_refill(8'h5A);
        expect_offer(a);
        accept_pop(p);
        check_value("pop_try_valid_o", pop_try_valid, 0);
        commit_entry(p);
        expect_quiet(2);
        miss_ready = 1'b1;
        step();
        miss_ready = 1'b0;
        expect_offer(b);
        accept_pop(p);
        commit_entry(p);
        check_value("empty_o", empty, 1);
        finish_test("dependency_wait", start);
    endtask

    task automatic rollback_replay();
        int        start;
        rtab_ptr_t a;
        rtab_ptr_t p;
        start = errors;
        allocate(make_req(8'h33, OP_CMO), DEPS_NONE, 1'b0, a);
        expect_offer(a);
        accept_pop(p);
        pop_rback      = 1'b1;
        pop_rback_ptr  = p;
        pop_rback_deps = WAIT_MISS;
        step();
        pop_rback      = 1'b0;
        pop_rback_deps = DEPS_NONE;
        expect_quiet(3);
        pulse_refill(8'h33);
        expect_offer(a);
        accept_pop(p);
        commit_entry(p);
        check_value("empty_o", empty, 1);
        finish_test("rollback_replay", start);
    endtask

    task automatic backpressure_hold();
        int        start;
        rtab_ptr_t a;
        rtab_ptr_t b;
        start = errors;
        allocate(make_req(8'h44, OP_LOAD), DEPS_NONE, 1'b0, a);
        expect_offer(a);
        // A second ready head arrives while the first is still on offer
        allocate(make_req(8'h45, OP_STORE), DEPS_NONE, 1'b0, b);
        repeat (5) begin
            expect_offer(a);
            step();
        end
        drain_all();
        finish_test("backpressure_hold", start);
    endtask

    initial begin
        void'($urandom(SEED));
        check_nline    = '0;
        alloc          = 1'b0;
        alloc_link     = 1'b0;
        alloc_req      = '0;
        alloc_deps     = DEPS_NONE;
        pop_try        = 1'b0;
        pop_commit     = 1'b0;
        pop_commit_ptr = '0;
        pop_rback      = 1'b0;
        pop_rback_ptr  = '0;
        pop_rback_deps = DEPS_NONE;
        refill         = 1'b0;
        refill_nline   = '0;
        miss_ready     = 1'b0;
        model_valid    = '0;
        @(posedge rst_n);
        step();
        reset_and_fill();
        replay_with_commit();
        list_order();
        dependency_wait();
        rollback_replay();
        backpressure_hold();
        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d property failures",
                 tests_run, tests_failed, errors, UUT.u_props.fails);
        if (tests_failed == 0 && errors == 0 && UUT.u_props.fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/rtab_pkg.sv
verilog/rtab_rr_arbiter.sv
verilog/rtab_entry_store.sv
verilog/rtab_dep_tracker.sv
verilog/rtab_pop_sched.sv
verilog/rtab_top.sv
bench/rtab_clkgen.sv
bench/rtab_props.sv
bench/rtab_tb.sv

// File: verilog/rtab_dep_tracker.sv
// Replay table dependency flags, loaded on allocation or rollback and cleared by refill and miss-ready
`timescale 1ns/1ns
`default_nettype none

module rtab_dep_tracker (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  rtab_pkg::rtab_vec_t                            alloc_slot_i,
    input  rtab_pkg::rtab_vec_t                            rback_slot_i,
    input  rtab_pkg::rtab_deps_t                           alloc_deps_i,
    input  rtab_pkg::rtab_deps_t                           rback_deps_i,
    input  logic [rtab_pkg::RTAB_ENTRIES-1:0][rtab_pkg::NLINE_W-1:0] nlines_i,
    input  logic                                           refill_i,
    input  logic [rtab_pkg::NLINE_W-1:0]                   refill_nline_i,
    input  logic                                           miss_ready_i,
    output rtab_pkg::rtab_vec_t                            nodeps_o
);
    import rtab_pkg::*;

    rtab_vec_t hit_q;
    rtab_vec_t rdy_q;
    rtab_vec_t hit_set;
    rtab_vec_t rdy_set;
    rtab_vec_t hit_clr;

    assign hit_set = (alloc_slot_i & {RTAB_ENTRIES{alloc_deps_i.mshr_hit}}) |
                     (rback_slot_i & {RTAB_ENTRIES{rback_deps_i.mshr_hit}});
    assign rdy_set = (alloc_slot_i & {RTAB_ENTRIES{alloc_deps_i.mshr_ready}}) |
                     (rback_slot_i & {RTAB_ENTRIES{rback_deps_i.mshr_ready}});

    // Only the refill of the entry's own line releases a pending-miss wait
    for (genvar i = 0; i < RTAB_ENTRIES; i++) begin : gen_refill
        assign hit_clr[i] = refill_i && (refill_nline_i == nlines_i[i]);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q <= '0;
            rdy_q <= '0;
        end else begin
            // Set wins over a clear in the same cycle
            hit_q <= (hit_q & ~hit_clr) | hit_set;
            rdy_q <= (rdy_q & ~{RTAB_ENTRIES{miss_ready_i}}) | rdy_set;
        end
    end

    assign nodeps_o = ~(hit_q | rdy_q);

endmodule

`default_nettype wire

// File: verilog/rtab_entry_store.sv
// Replay table entry store: payloads, list flags and next pointers, line check and slot choice
`timescale 1ns/1ns
`default_nettype none

module rtab_entry_store (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,

    input  logic [rtab_pkg::NLINE_W-1:0]                   check_nline_i,
    output logic                                           check_hit_o,

    input  logic                                           alloc_i,
    input  logic                                           alloc_link_i,
    input  rtab_pkg::rtab_req_t                            alloc_req_i,

    input  rtab_pkg::rtab_vec_t                            popped_i,
    input  logic                                           pop_commit_i,
    input  rtab_pkg::rtab_ptr_t                            pop_commit_ptr_i,
    input  logic                                           pop_rback_i,
    input  rtab_pkg::rtab_ptr_t                            pop_rback_ptr_i,

    output logic                                           empty_o,
    output logic                                           full_o,
    output rtab_pkg::rtab_vec_t                            valid_o,
    output rtab_pkg::rtab_vec_t                            head_o,
    output rtab_pkg::rtab_vec_t                            tail_o,
    output rtab_pkg::rtab_ptr_arr_t                        next_o,
    output rtab_pkg::rtab_req_arr_t                        entries_o,
    output logic [rtab_pkg::RTAB_ENTRIES-1:0][rtab_pkg::NLINE_W-1:0] nlines_o,
    output rtab_pkg::rtab_vec_t                            alloc_slot_o,
    output rtab_pkg::rtab_vec_t                            rback_slot_o
);
    import rtab_pkg::*;

    rtab_req_arr_t req_q;
    rtab_ptr_arr_t next_q;
    rtab_vec_t     valid_q;
    rtab_vec_t     head_q;
    rtab_vec_t     tail_q;

    rtab_vec_t     check_hit;
    rtab_vec_t     link_tail;
    rtab_vec_t     free_vec;
    rtab_vec_t     free_1hot;
    rtab_ptr_t     free_ptr;
    rtab_vec_t     commit_vec;
    rtab_vec_t     head_set;
    rtab_vec_t     head_rst;

    for (genvar i = 0; i < RTAB_ENTRIES; i++) begin : gen_line
        assign nlines_o[i]  = req_q[i].nline;
        assign check_hit[i] = valid_q[i] && (req_q[i].nline == check_nline_i);
    end

    assign check_hit_o = |check_hit;

    // Old tail of the checked list, the one a linked allocation hangs behind
    assign link_tail = check_hit & tail_q & {RTAB_ENTRIES{alloc_link_i}};

    // Lowest free slot as a one-hot vector
    assign free_vec  = ~valid_q;
    assign free_1hot = free_vec & (~free_vec + rtab_vec_t'(1));
    assign free_ptr  = rtab_vec_to_ptr(free_1hot);

    assign alloc_slot_o = free_1hot & {RTAB_ENTRIES{alloc_i | alloc_link_i}};
    assign rback_slot_o = rtab_ptr_to_vec(pop_rback_ptr_i) & {RTAB_ENTRIES{pop_rback_i}};
    assign commit_vec   = rtab_ptr_to_vec(pop_commit_ptr_i) & {RTAB_ENTRIES{pop_commit_i}};

    // A new list gets a head, an appended entry is reached only through the walk
    assign head_set = (free_1hot & {RTAB_ENTRIES{alloc_i}}) | rback_slot_o;
    assign head_rst = popped_i | (free_1hot & {RTAB_ENTRIES{alloc_link_i}});

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            next_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_slot_o) & ~commit_vec;
            head_q  <= (head_q & ~head_rst) | head_set;
            tail_q  <= (tail_q & ~link_tail) | alloc_slot_o;
            for (int i = 0; i < RTAB_ENTRIES; i++) begin
                if (link_tail[i]) begin
                    next_q[i] <= free_ptr;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (alloc_slot_o[i]) begin
                req_q[i] <= alloc_req_i;
            end
        end
    end

    assign empty_o   = ~|valid_q;
    assign full_o    = &valid_q;
    assign valid_o   = valid_q;
    assign head_o    = head_q;
    assign tail_o    = tail_q;
    assign next_o    = next_q;
    assign entries_o = req_q;

endmodule

`default_nettype wire

// File: verilog/rtab_pkg.sv
// Shared sizes, request and dependency types, and one-hot helpers for the replay table
`default_nettype none

package rtab_pkg;

    localparam int RTAB_ENTRIES = 4;
    localparam int NLINE_W      = 8;
    localparam int OFFSET_W     = 4;
    localparam int ID_W         = 4;
    localparam int PTR_W        = 2;

    typedef logic [PTR_W-1:0]        rtab_ptr_t;
    typedef logic [RTAB_ENTRIES-1:0] rtab_vec_t;

    // Carried in the payload only, the table never decodes it
    typedef enum logic [1:0] {
        OP_LOAD,
        OP_STORE,
        OP_PREFETCH,
        OP_CMO
    } rtab_op_e;

    typedef struct packed {
        logic [NLINE_W-1:0]  nline;
        logic [OFFSET_W-1:0] offset;
        rtab_op_e            op;
        logic [ID_W-1:0]     id;
    } rtab_req_t;

    typedef rtab_req_t [RTAB_ENTRIES-1:0] rtab_req_arr_t;
    typedef rtab_ptr_t [RTAB_ENTRIES-1:0] rtab_ptr_arr_t;

    typedef struct packed {
        logic mshr_hit;
        logic mshr_ready;
    } rtab_deps_t;

    typedef enum logic [1:0] {
        POP_TRY_HEAD,
        POP_TRY_NEXT,
        POP_TRY_NEXT_WAIT
    } rtab_pop_state_e;

    // Index of the lowest set bit, zero for an empty vector
    function automatic rtab_ptr_t rtab_vec_to_ptr(input rtab_vec_t vec);
        rtab_ptr_t ptr;
        ptr = '0;
        for (int i = RTAB_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                ptr = rtab_ptr_t'(i);
            end
        end
        return ptr;
    endfunction

    function automatic rtab_vec_t rtab_ptr_to_vec(input rtab_ptr_t ptr);
        rtab_vec_t vec;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            vec[i] = (rtab_ptr_t'(i) == ptr);
        end
        return vec;
    endfunction

endpackage

`default_nettype wire

// File: verilog/rtab_pop_sched.sv
// Pop-try FSM of the replay table, picks a ready list head and walks the rest of its list
`timescale 1ns/1ns
`default_nettype none

module rtab_pop_sched (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  rtab_pkg::rtab_vec_t      valid_i,
    input  rtab_pkg::rtab_vec_t      head_i,
    input  rtab_pkg::rtab_vec_t      tail_i,
    input  rtab_pkg::rtab_vec_t      nodeps_i,
    input  rtab_pkg::rtab_ptr_arr_t  next_i,
    input  rtab_pkg::rtab_req_arr_t  entries_i,
    input  logic                     pop_try_i,
    input  logic                     pop_rback_i,
    output logic                     pop_try_valid_o,
    output rtab_pkg::rtab_req_t      pop_try_req_o,
    output rtab_pkg::rtab_ptr_t      pop_try_ptr_o,
    output rtab_pkg::rtab_vec_t      popped_o
);
    import rtab_pkg::*;

    rtab_pop_state_e state_q, state_d;
    rtab_vec_t       walk_q, walk_d;
    rtab_vec_t       ready;
    rtab_vec_t       gnt;
    rtab_vec_t       sel;
    logic            head_taken;
    logic            sel_is_tail;

    assign ready = valid_i & head_i & nodeps_i;

    rtab_rr_arbiter u_arb (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (ready),
        .ready_i (head_taken),
        .gnt_o   (gnt)
    );

    assign sel             = (state_q == POP_TRY_HEAD) ? gnt : walk_q;
    assign pop_try_valid_o = (state_q == POP_TRY_HEAD) ? |ready : 1'b1;
    assign pop_try_ptr_o   = rtab_vec_to_ptr(sel);
    assign pop_try_req_o   = entries_i[pop_try_ptr_o];
    assign popped_o        = sel & {RTAB_ENTRIES{pop_try_i}};
    assign sel_is_tail     = (sel & tail_i) != '0;
    assign head_taken      = (state_q == POP_TRY_HEAD) && pop_try_i && !pop_rback_i;

    always_comb begin
        state_d = state_q;
        walk_d  = walk_q;
        case (state_q)
            POP_TRY_HEAD: begin
                // A rollback for the last tail offered may still arrive here
                if (head_taken && !sel_is_tail) begin
                    state_d = POP_TRY_NEXT;
                    walk_d  = rtab_ptr_to_vec(next_i[pop_try_ptr_o]);
                end
            end
            POP_TRY_NEXT, POP_TRY_NEXT_WAIT: begin
                if (pop_rback_i && state_q == POP_TRY_NEXT) begin
                    state_d = POP_TRY_HEAD;
                end else if (pop_try_i) begin
                    if (sel_is_tail) begin
                        state_d = POP_TRY_HEAD;
                    end else begin
                        state_d = POP_TRY_NEXT;
                        walk_d  = rtab_ptr_to_vec(next_i[pop_try_ptr_o]);
                    end
                end else begin
                    state_d = POP_TRY_NEXT_WAIT;
                end
            end
            default: begin
                state_d = POP_TRY_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POP_TRY_HEAD;
            walk_q  <= '0;
        end else begin
            state_q <= state_d;
            walk_q  <= walk_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rtab_rr_arbiter.sv
// Round-robin one-hot arbiter for list heads, priority advances only when a grant is taken
`timescale 1ns/1ns
`default_nettype none

module rtab_rr_arbiter (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  rtab_pkg::rtab_vec_t req_i,
    input  logic                ready_i,
    output rtab_pkg::rtab_vec_t gnt_o
);
    import rtab_pkg::*;

    rtab_vec_t last_q;
    rtab_vec_t hold_q;
    rtab_vec_t mask;
    rtab_vec_t req_hi;
    rtab_vec_t gnt_hi;
    rtab_vec_t gnt_all;
    rtab_vec_t gnt_rr;

    // Requests strictly above the last accepted grant
    assign mask    = ~((last_q << 1) - rtab_vec_t'(1));
    assign req_hi  = req_i & mask;
    assign gnt_hi  = req_hi & (~req_hi + rtab_vec_t'(1));
    assign gnt_all = req_i & (~req_i + rtab_vec_t'(1));
    assign gnt_rr  = (req_hi != '0) ? gnt_hi : gnt_all;

    // An offered grant is kept while its request stays up
    assign gnt_o = ((hold_q & req_i) != '0) ? hold_q : gnt_rr;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= '0;
            hold_q <= '0;
        end else if (ready_i) begin
            last_q <= gnt_o;
            hold_q <= '0;
        end else begin
            hold_q <= gnt_o;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rtab_top.sv
// Replay table top level, joins entry store, dependency tracker and pop scheduler to the cache
`timescale 1ns/1ns
`default_nettype none

module rtab_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    input  logic [rtab_pkg::NLINE_W-1:0]   check_nline_i,
    output logic                           check_hit_o,

    input  logic                           alloc_i,
    input  logic                           alloc_link_i,
    input  rtab_pkg::rtab_req_t            alloc_req_i,
    input  rtab_pkg::rtab_deps_t           alloc_deps_i,

    output logic                           pop_try_valid_o,
    input  logic                           pop_try_i,
    output rtab_pkg::rtab_req_t            pop_try_req_o,
    output rtab_pkg::rtab_ptr_t            pop_try_ptr_o,

    input  logic                           pop_commit_i,
    input  rtab_pkg::rtab_ptr_t            pop_commit_ptr_i,

    input  logic                           pop_rback_i,
    input  rtab_pkg::rtab_ptr_t            pop_rback_ptr_i,
    input  rtab_pkg::rtab_deps_t           pop_rback_deps_i,

    input  logic                           refill_i,
    input  logic [rtab_pkg::NLINE_W-1:0]   refill_nline_i,
    input  logic                           miss_ready_i,

    output logic                           empty_o,
    output logic                           full_o
);
    import rtab_pkg::*;

    rtab_vec_t                              valid;
    rtab_vec_t                              head;
    rtab_vec_t                              tail;
    rtab_ptr_arr_t                          next;
    rtab_req_arr_t                          entries;
    logic [RTAB_ENTRIES-1:0][NLINE_W-1:0]   nlines;
    rtab_vec_t                              alloc_slot;
    rtab_vec_t                              rback_slot;
    rtab_vec_t                              nodeps;
    rtab_vec_t                              popped;

    rtab_entry_store u_store (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .check_nline_i    (check_nline_i),
        .check_hit_o      (check_hit_o),
        .alloc_i          (alloc_i),
        .alloc_link_i     (alloc_link_i),
        .alloc_req_i      (alloc_req_i),
        .popped_i         (popped),
        .pop_commit_i     (pop_commit_i),
        .pop_commit_ptr_i (pop_commit_ptr_i),
        .pop_rback_i      (pop_rback_i),
        .pop_rback_ptr_i  (pop_rback_ptr_i),
        .empty_o          (empty_o),
        .full_o           (full_o),
        .valid_o          (valid),
        .head_o           (head),
        .tail_o           (tail),
        .next_o           (next),
        .entries_o        (entries),
        .nlines_o         (nlines),
        .alloc_slot_o     (alloc_slot),
        .rback_slot_o     (rback_slot)
    );

    rtab_dep_tracker u_deps (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .alloc_slot_i   (alloc_slot),
        .rback_slot_i   (rback_slot),
        .alloc_deps_i   (alloc_deps_i),
        .rback_deps_i   (pop_rback_deps_i),
        .nlines_i       (nlines),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .miss_ready_i   (miss_ready_i),
        .nodeps_o       (nodeps)
    );

    rtab_pop_sched u_sched (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .valid_i         (valid),
        .head_i          (head),
        .tail_i          (tail),
        .nodeps_i        (nodeps),
        .next_i          (next),
        .entries_i       (entries),
        .pop_try_i       (pop_try_i),
        .pop_rback_i     (pop_rback_i),
        .pop_try_valid_o (pop_try_valid_o),
        .pop_try_req_o   (pop_try_req_o),
        .pop_try_ptr_o   (pop_try_ptr_o),
        .popped_o        (popped)
    );

endmodule

`default_nettype wire
